//--- design/cpuPkg.sv
package cpuPkg;

	typedef logic [15:0] word_t;

	// instruction bits 15:11
	typedef enum logic [4:0] {
		ADD  = 5'd0,
		SUB  = 5'd1,
		AND  = 5'd2,
		OR   = 5'd3,
		XOR  = 5'd4,
		ADDI = 5'd5,
		LD   = 5'd6,
		ST   = 5'd7,
		PUSH = 5'd8,
		JMP  = 5'd9,  // pc + imm, pc already past this instruction
		BZ   = 5'd10,
		CALL = 5'd11,
		RET  = 5'd12,
		HALT = 5'd13
	} opcode_t;

	// field positions; ST and PUSH take their data register from the rd field
	localparam int OPC_LO = 11;
	localparam int RD_LO  = 0;
	localparam int RS1_LO = 3;
	localparam int RS2_LO = 6;
	localparam int IMM_LO = 6;
	localparam int IMM_W  = 5;

	typedef enum logic [2:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_DEC
	} aluFunc_t;

	typedef enum logic [1:0] {PC_LR, PC_ALU, PC_BUS, PC_INC} pcSel_t;

	typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_SP} op1Sel_t;

	typedef enum logic [2:0] {BUS_MEM, BUS_PC, BUS_LR, BUS_SP, BUS_ALU, BUS_RS2} busSrc_t;

	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
		logic overflow;
	} flags_t;

	typedef struct packed {
		aluFunc_t aluFunc;
		pcSel_t   pcSel;
		op1Sel_t  op1Sel;
		busSrc_t  busSrc;
		logic     op2Imm;    // immediate instead of rs2
		logic     wdBus;     // reg write data from bus, else ALU result
		logic     lrFromPc;  // link loads pc, else bus
		logic     rs2FromRd; // second read port addressed by rd field
		logic     adrAlu;    // address from ALU output reg, else pc
		logic     regWe;
		logic     pcWe;
		logic     lrWe;
		logic     spWe;
		logic     irWe;
		logic     aluOutWe;
		logic     flagsWe;
	} ctrl_t;

endpackage

//--- design/alu.sv
module alu import cpuPkg::*; (
	input  word_t    op1,
	input  word_t    op2,
	input  aluFunc_t func,
	output word_t    result,
	output flags_t   flags
);

	logic [16:0] sum;  // bit 16 is carry or borrow
	word_t       b;
	logic        isSub;
	logic        arith;

	always_comb begin
		b = (func == ALU_DEC) ? 16'd1 : op2;
		isSub = (func == ALU_SUB) || (func == ALU_DEC);
		arith = (func == ALU_ADD) || isSub;
		sum = isSub ? ({1'b0, op1} - {1'b0, b}) : ({1'b0, op1} + {1'b0, b});

		case (func)
			ALU_ADD, ALU_SUB, ALU_DEC: result = sum[15:0];
			ALU_AND: result = op1 & op2;
			ALU_OR:  result = op1 | op2;
			ALU_XOR: result = op1 ^ op2;
			default: result = op2;  // pass
		endcase

		flags.zero     = (result == '0);
		flags.negative = result[15];
		flags.carry    = arith & sum[16];
		// sign change not explained by operand signs
		if (isSub)
			flags.overflow = (op1[15] != b[15]) && (sum[15] != op1[15]);
		else
			flags.overflow = arith && (op1[15] == b[15]) && (sum[15] != op1[15]);
	end

endmodule

//--- design/regBlock.sv
module regBlock import cpuPkg::*; (
	input  logic       Clock,
	input  logic       rst,
	input  logic       we,
	input  logic [2:0] rs1,
	input  logic [2:0] rs2,
	input  logic [2:0] rw,
	input  word_t      wData,
	output word_t      rd1,
	output word_t      rd2
);

	word_t regs [8];  // r0 is an ordinary register

	always_ff @(posedge Clock) begin
		if (rst) begin
			for (int i = 0; i < 8; i++)
				regs[3'(i)] <= '0;
		end else if (we) begin
			regs[rw] <= wData;
		end
	end

	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

endmodule

//--- design/busReg.sv
module busReg #(
	parameter type T = logic [15:0],
	parameter T    RESET_VAL = '0
) (
	input  logic Clock,
	input  logic rst,
	input  logic we,
	input  T     d,
	output T     q
);

	always_ff @(posedge Clock) begin
		if (rst)
			q <= RESET_VAL;
		else if (we)
			q <= d;
	end

endmodule

//--- design/datapath.sv
module datapath import cpuPkg::*; #(
	parameter word_t RESET_PC = 16'h0000,
	parameter word_t RESET_SP = 16'hFFFF
) (
	input  logic    Clock,
	input  logic    rst,
	input  ctrl_t   ctrl,
	input  word_t   memData,
	output opcode_t opcode,
	output flags_t  flags,
	output word_t   adr,
	output word_t   busOut
);

	word_t      pc, lr, sp, ir, aluOut;
	word_t      pcIn, lrIn, sysBus, regWData;
	word_t      rd1, rd2, op1, op2, imm, aluRes;
	flags_t     aluFlags;
	logic [2:0] rs2Addr;

	assign opcode = opcode_t'(ir[OPC_LO +: 5]);
	assign imm = {{(16 - IMM_W){ir[IMM_LO + IMM_W - 1]}}, ir[IMM_LO +: IMM_W]};
	assign rs2Addr = ctrl.rs2FromRd ? ir[RD_LO +: 3] : ir[RS2_LO +: 3];

	assign op2 = ctrl.op2Imm ? imm : rd2;
	assign regWData = ctrl.wdBus ? sysBus : aluRes;
	assign lrIn = ctrl.lrFromPc ? pc : sysBus;
	assign adr = ctrl.adrAlu ? aluOut : pc;
	assign busOut = sysBus;  // store data leaves through the bus

	always_comb begin
		case (ctrl.op1Sel)
			OP1_PC:  op1 = pc;
			OP1_SP:  op1 = sp;
			default: op1 = rd1;
		endcase
	end

	always_comb begin
		case (ctrl.pcSel)
			PC_LR:   pcIn = lr;
			PC_ALU:  pcIn = aluOut;
			PC_BUS:  pcIn = sysBus;
			default: pcIn = pc + 16'd1;
		endcase
	end

	// one source at a time onto the internal bus
	always_comb begin
		case (ctrl.busSrc)
			BUS_PC:  sysBus = pc;
			BUS_LR:  sysBus = lr;
			BUS_SP:  sysBus = sp;
			BUS_ALU: sysBus = aluOut;
			BUS_RS2: sysBus = rd2;
			default: sysBus = memData;
		endcase
	end

	regBlock u_regBlock (
		.Clock (Clock),
		.rst   (rst),
		.we    (ctrl.regWe),
		.rs1   (ir[RS1_LO +: 3]),
		.rs2   (rs2Addr),
		.rw    (ir[RD_LO +: 3]),
		.wData (regWData),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	alu u_alu (
		.op1    (op1),
		.op2    (op2),
		.func   (ctrl.aluFunc),
		.result (aluRes),
		.flags  (aluFlags)
	);

	busReg #(.T(word_t), .RESET_VAL(RESET_PC)) u_pcReg (
		.Clock (Clock), .rst (rst), .we (ctrl.pcWe), .d (pcIn), .q (pc)
	);
	busReg #(.T(word_t)) u_lrReg (
		.Clock (Clock), .rst (rst), .we (ctrl.lrWe), .d (lrIn), .q (lr)
	);
	busReg #(.T(word_t), .RESET_VAL(RESET_SP)) u_spReg (
		.Clock (Clock), .rst (rst), .we (ctrl.spWe), .d (aluRes), .q (sp)
	);
	busReg #(.T(word_t)) u_irReg (
		.Clock (Clock), .rst (rst), .we (ctrl.irWe), .d (sysBus), .q (ir)
	);
	busReg #(.T(word_t)) u_aluOutReg (
		.Clock (Clock), .rst (rst), .we (ctrl.aluOutWe), .d (aluRes), .q (aluOut)
	);
	busReg #(.T(flags_t)) u_flagsReg (
		.Clock (Clock), .rst (rst), .we (ctrl.flagsWe), .d (aluFlags), .q (flags)
	);

endmodule

//--- design/controlFsm.sv
module controlFsm import cpuPkg::*; (
	input  logic    Clock,
	input  logic    rst,
	input  opcode_t opcode,
	input  flags_t  flags,
	input  logic    wbAck,
	input  logic    timeout,
	output ctrl_t   ctrl,
	output logic    timerStart,
	output logic    wbCyc,
	output logic    wbStb,
	output logic    wbWe,
	output logic    halted,
	output logic    busError
);

	typedef enum logic [2:0] {
		FETCH, DECODE, EXECUTE, ADDRESS, MEMORY, PUSHDEC, STOP
	} state_t;

	state_t state;
	logic   cyc;
	logic   regOp;

	assign regOp = opcode inside {ADD, SUB, AND, OR, XOR};
	assign wbCyc = cyc;
	assign wbStb = cyc;

	always_ff @(posedge Clock) begin
		if (rst) begin
			state    <= FETCH;
			cyc      <= 1'b0;
			wbWe     <= 1'b0;
			halted   <= 1'b0;
			busError <= 1'b0;
		end else begin
			case (state)
				FETCH, MEMORY: begin
					if (!cyc) begin
						cyc <= 1'b1;  // only after reset or a data cycle
					end else if (wbAck) begin
						cyc   <= 1'b0;
						wbWe  <= 1'b0;
						state <= (state == FETCH) ? DECODE : FETCH;
					end else if (timeout) begin
						cyc      <= 1'b0;
						halted   <= 1'b1;
						busError <= 1'b1;
						state    <= STOP;
					end
				end
				DECODE: begin
					case (opcode)
						LD, ST:  state <= ADDRESS;
						PUSH:    state <= PUSHDEC;
						HALT: begin
							halted <= 1'b1;
							state  <= STOP;
						end
						default: state <= EXECUTE;
					endcase
				end
				EXECUTE: begin
					cyc   <= 1'b1;  // straight into the next fetch
					state <= FETCH;
				end
				ADDRESS, PUSHDEC: begin
					cyc   <= 1'b1;
					wbWe  <= (opcode != LD);
					state <= MEMORY;
				end
				default: state <= STOP;
			endcase
		end
	end

	always_comb begin
		ctrl = '0;
		timerStart = 1'b0;
		case (state)
			FETCH: begin
				ctrl.busSrc = BUS_MEM;
				ctrl.pcSel  = PC_INC;
				ctrl.irWe   = cyc & wbAck;
				ctrl.pcWe   = cyc & wbAck;
				timerStart  = !cyc;
			end
			DECODE: begin
				// branch target, used by JMP, BZ and CALL
				ctrl.op1Sel   = OP1_PC;
				ctrl.op2Imm   = 1'b1;
				ctrl.aluFunc  = ALU_ADD;
				ctrl.aluOutWe = 1'b1;
			end
			EXECUTE: begin
				case (opcode)
					SUB:     ctrl.aluFunc = ALU_SUB;
					AND:     ctrl.aluFunc = ALU_AND;
					OR:      ctrl.aluFunc = ALU_OR;
					XOR:     ctrl.aluFunc = ALU_XOR;
					default: ctrl.aluFunc = ALU_ADD;
				endcase
				ctrl.op1Sel   = OP1_RS1;
				ctrl.op2Imm   = (opcode == ADDI);
				ctrl.regWe    = regOp || (opcode == ADDI);
				ctrl.flagsWe  = regOp;
				ctrl.pcSel    = (opcode == RET) ? PC_LR : PC_ALU;
				ctrl.pcWe     = (opcode inside {JMP, CALL, RET}) ||
					(opcode == BZ && flags.zero);
				ctrl.lrFromPc = 1'b1;
				ctrl.lrWe     = (opcode == CALL);
				timerStart    = 1'b1;
			end
			ADDRESS: begin
				ctrl.op1Sel   = OP1_RS1;
				ctrl.op2Imm   = 1'b1;
				ctrl.aluFunc  = ALU_ADD;
				ctrl.aluOutWe = 1'b1;
				timerStart    = 1'b1;
			end
			PUSHDEC: begin
				ctrl.op1Sel   = OP1_SP;
				ctrl.aluFunc  = ALU_DEC;
				ctrl.spWe     = 1'b1;
				ctrl.aluOutWe = 1'b1;  // new sp is the store address
				timerStart    = 1'b1;
			end
			MEMORY: begin
				ctrl.adrAlu    = 1'b1;
				ctrl.rs2FromRd = 1'b1;
				ctrl.busSrc    = wbWe ? BUS_RS2 : BUS_MEM;
				ctrl.wdBus     = 1'b1;
				ctrl.regWe     = cyc && wbAck && (opcode == LD);
				timerStart     = !cyc;
			end
			default: ;
		endcase
	end

endmodule

//--- design/waitTimer.sv
module waitTimer #(
	parameter int ACK_TIMEOUT = 16
) (
	input  logic Clock,
	input  logic rst,
	input  logic start,
	input  logic ack,
	output logic timeout
);

	localparam int CW = $clog2(ACK_TIMEOUT + 1);

	logic [CW-1:0] count;
	logic          armed;  // a bus cycle is waiting for ack

	always_ff @(posedge Clock) begin
		if (rst) begin
			armed <= 1'b0;
			count <= '0;
		end else if (start) begin
			armed <= 1'b1;
			count <= '0;
		end else if (armed) begin
			if (ack)
				armed <= 1'b0;
			else if (!timeout)
				count <= count + 1'b1;  // holds once expired
		end
	end

	assign timeout = armed && (count == CW'(ACK_TIMEOUT));

endmodule

//--- design/cpuTop.sv
module cpuTop import cpuPkg::*; #(
	parameter word_t RESET_PC    = 16'h0000,
	parameter word_t RESET_SP    = 16'hFFFF,
	parameter int    ACK_TIMEOUT = 16
) (
	input  logic  Clock,
	input  logic  rst,
	output word_t wbAdr,
	output word_t wbDatOut,
	input  word_t wbDatIn,
	output logic  wbWe,
	output logic  wbCyc,
	output logic  wbStb,
	input  logic  wbAck,
	output logic  halted,
	output logic  busError
);

	ctrl_t   ctrl;
	opcode_t opcode;
	flags_t  flags;
	logic    timerStart;
	logic    timeout;

	controlFsm u_controlFsm (
		.Clock      (Clock),
		.rst        (rst),
		.opcode     (opcode),
		.flags      (flags),
		.wbAck      (wbAck),
		.timeout    (timeout),
		.ctrl       (ctrl),
		.timerStart (timerStart),
		.wbCyc      (wbCyc),
		.wbStb      (wbStb),
		.wbWe       (wbWe),
		.halted     (halted),
		.busError   (busError)
	);

	waitTimer #(.ACK_TIMEOUT(ACK_TIMEOUT)) u_waitTimer (
		.Clock   (Clock),
		.rst     (rst),
		.start   (timerStart),
		.ack     (wbAck),
		.timeout (timeout)
	);

	datapath #(.RESET_PC(RESET_PC), .RESET_SP(RESET_SP)) u_datapath (
		.Clock   (Clock),
		.rst     (rst),
		.ctrl    (ctrl),
		.memData (wbDatIn),
		.opcode  (opcode),
		.flags   (flags),
		.adr     (wbAdr),
		.busOut  (wbDatOut)
	);

endmodule

//--- dv/cpuChecker.sv
module cpuChecker import cpuPkg::*; #(
	parameter int MAX_EXP = 16
) (
	input  logic  Clock,
	input  logic  rst,
	input  word_t wbAdr,
	input  word_t wbDatOut,
	input  logic  wbWe,
	input  logic  wbCyc,
	input  logic  wbStb,
	input  logic  wbAck,
	input  logic  halted,
	input  logic  busError,
	input  int    runIdx,
	input  int    expCount,
	input  word_t expAdr [MAX_EXP],
	input  word_t expDat [MAX_EXP],
	input  logic  expBusError,
	output int    errorCount,
	output int    checkCount
);

	int   errs = 0;
	int   checks = 0;
	int   storeIdx = 0;  // stores seen since reset
	logic haltedPrev = 1'b0;

	assign errorCount = errs;
	assign checkCount = checks;

	function automatic string testName(input int idx);
		if (idx == 1)
			return "mainProgram";
		else
			return "busTimeout";
	endfunction

	always @(posedge Clock) begin
		if (rst) begin
			storeIdx = 0;
			haltedPrev = 1'b0;
		end else begin
			// classic master keeps stb equal to cyc
			if (wbStb !== wbCyc) begin
				errs++;
				$display("FAILED %s strobe: expected %b, actual %b",
					testName(runIdx), wbCyc, wbStb);
			end
			if (wbCyc && wbStb && wbWe && wbAck) begin  // write completes here
				if (storeIdx >= expCount) begin
					errs++;
					$display("ERROR: %s made an unexpected store of %h to %h",
						testName(runIdx), wbDatOut, wbAdr);
				end else begin
					checks++;
					if (wbAdr !== expAdr[4'(storeIdx)]) begin
						errs++;
						$display("FAILED %s store %0d address: expected %h, actual %h",
							testName(runIdx), storeIdx, expAdr[4'(storeIdx)], wbAdr);
					end
					if (wbDatOut !== expDat[4'(storeIdx)]) begin
						errs++;
						$display("FAILED %s store %0d data: expected %h, actual %h",
							testName(runIdx), storeIdx, expDat[4'(storeIdx)], wbDatOut);
					end
				end
				storeIdx++;
			end
			if (halted && wbCyc) begin
				errs++;
				$display("ERROR: %s started a bus cycle after halting", testName(runIdx));
			end
			// end state, once per run
			if (halted && !haltedPrev) begin
				checks++;
				if (storeIdx != expCount) begin
					errs++;
					$display("FAILED %s store count: expected %0d, actual %0d",
						testName(runIdx), expCount, storeIdx);
				end
				if (busError !== expBusError) begin
					errs++;
					$display("FAILED %s busError at halt: expected %b, actual %b",
						testName(runIdx), expBusError, busError);
				end
			end
			haltedPrev = halted;
		end
	end

endmodule

//--- dv/cpuTb.sv
module cpuTb import cpuPkg::*; ();

	localparam word_t HANG_ADR     = 16'h7777;  // slave never acks here
	localparam int    IMG_WORDS    = 32;
	localparam int    MAX_EXP      = 16;
	localparam int    RUN_LIMIT    = 3000;  // cycles from reset to halted
	localparam int    QUIET_CYCLES = 40;

	logic  Clock = 1'b0;
	logic  rst = 1'b1;
	word_t wbDatIn = '0;
	logic  wbAck = 1'b0;
	word_t wbAdr;
	word_t wbDatOut;
	logic  wbWe;
	logic  wbCyc;
	logic  wbStb;
	logic  halted;
	logic  busError;

	word_t mem [0:65535];
	word_t fileData [0:127] = '{default: '0};
	word_t expAdr [MAX_EXP];
	word_t expDat [MAX_EXP];
	int    expCount = 0;
	logic  expBusError = 1'b0;
	int    runIdx = 1;
	int    errorCount;
	int    checkCount;
	logic  pending = 1'b0;  // slave is counting wait states
	int    waitLeft = 0;

	always #10 Clock = ~Clock;

	cpuTop #(.RESET_PC(16'h0000), .RESET_SP(16'hFFFF), .ACK_TIMEOUT(16)) u_cpuTop (
		.Clock    (Clock),
		.rst      (rst),
		.wbAdr    (wbAdr),
		.wbDatOut (wbDatOut),
		.wbDatIn  (wbDatIn),
		.wbWe     (wbWe),
		.wbCyc    (wbCyc),
		.wbStb    (wbStb),
		.wbAck    (wbAck),
		.halted   (halted),
		.busError (busError)
	);

	cpuChecker #(.MAX_EXP(MAX_EXP)) u_cpuChecker (
		.Clock       (Clock),
		.rst         (rst),
		.wbAdr       (wbAdr),
		.wbDatOut    (wbDatOut),
		.wbWe        (wbWe),
		.wbCyc       (wbCyc),
		.wbStb       (wbStb),
		.wbAck       (wbAck),
		.halted      (halted),
		.busError    (busError),
		.runIdx      (runIdx),
		.expCount    (expCount),
		.expAdr      (expAdr),
		.expDat      (expDat),
		.expBusError (expBusError),
		.errorCount  (errorCount),
		.checkCount  (checkCount)
	);

	// background pattern, then the selected program image at address 0
	task automatic loadImage(input int r);
		int base;
		base = (r == 1) ? 'h00 : 'h20;
		for (int a = 0; a < 65536; a++)
			mem[16'(a)] = 16'(a) ^ 16'h5A5A;
		for (int i = 0; i < IMG_WORDS; i++)
			mem[16'(i)] = fileData[7'(base + i)];
	endtask

	task automatic loadExpected(input int r);
		int base;
		base = (r == 1) ? 'h40 : 'h60;
		expCount = int'(fileData[7'(base)]);
		expBusError = fileData[7'(base + 1)][0];
		for (int i = 0; i < expCount && i < MAX_EXP; i++) begin
			expAdr[4'(i)] = fileData[7'(base + 2 + 2 * i)];
			expDat[4'(i)] = fileData[7'(base + 3 + 2 * i)];
		end
	endtask

	task automatic resetCore();
		rst <= 1'b1;
		repeat (2) @(posedge Clock);
		rst <= 1'b0;
	endtask

	task automatic waitHalt(output bit done);
		int cycles;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < RUN_LIMIT) begin
			@(posedge Clock);
			cycles++;
			done = halted;
		end
	endtask

	// checker flags any bus activity in this window
	task automatic watchQuiet();
		int cycles;
		cycles = 0;
		while (cycles < QUIET_CYCLES) begin
			@(posedge Clock);
			cycles++;
		end
	endtask

	// Wishbone slave with 0 to 3 random wait states per cycle
	always @(posedge Clock) begin
		if (rst) begin
			wbAck <= 1'b0;
			pending = 1'b0;
			loadImage(runIdx);
		end else if (wbAck) begin
			wbAck <= 1'b0;  // single cycle ack
		end else if (wbCyc && wbStb && wbAdr != HANG_ADR) begin
			if (!pending) begin
				pending = 1'b1;
				waitLeft = $urandom_range(3, 0);
			end
			if (waitLeft == 0) begin
				pending = 1'b0;
				wbAck <= 1'b1;
				if (wbWe)
					mem[wbAdr] = wbDatOut;
				else
					wbDatIn <= mem[wbAdr];
			end else begin
				waitLeft--;
			end
		end
	end

	initial begin
		bit timedOut;
		bit done;
		timedOut = 1'b0;
		void'($urandom(32'hb843_8c04));
		$readmemh("dv/programInput.txt", fileData);
		for (int r = 1; r <= 2 && !timedOut; r++) begin
			loadExpected(r);
			runIdx = r;
			resetCore();
			waitHalt(done);
			if (!done) begin
				$display("ERROR: run %0d did not halt within %0d cycles", r, RUN_LIMIT);
				timedOut = 1'b1;
			end else begin
				watchQuiet();
			end
		end
		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount,
			timedOut ? 1 : 0);
		if (timedOut || errorCount != 0)
			$display("*** TEST FAILED ***");
		else
			$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- dv/programInput.txt
// hex words for $readmemh; @00 main program, @20 bus timeout program
// @40 and @60 expected results: store count, busError, then address and data pairs
@00
2941 28C2 008B 088C 211D  // ADDI r1 5, ADDI r2 3, ADD, SUB, XOR
3C03 3C44 3C85 115E 18CF  // ST r3 r4 r5, AND, OR
3CC6 3D07 37C6 3D46       // ST r6 r7, LD r6 from FFFF, ST r6
084F 5040 3D81 088F 5040  // SUB to zero, BZ taken, skipped ST, SUB nonzero, BZ not taken
3DC2 4840 3D81 5900 3E03  // ST r2, JMP over ST, CALL, ST r3 after return
4005 4001 6800 3E44 6000  // PUSH r5, PUSH r1, HALT, subroutine ST r4, RET
@20
33C1 3C01 300A 6800       // LD r1 pointer, ST r1, LD through pointer hangs, HALT
@2F
7777                      // pointer to the address that never acks
@40
000B 0000
FFF0 0008 FFF1 0002 FFF2 000A FFF3 0008 FFF4 000D FFF5 A5A5
FFF7 0003 FFF9 0002 FFF8 0008 FFFE 000A FFFD 0005
@60
0001 0001
FFF0 7777

//--- files.f
design/cpuPkg.sv
design/alu.sv
design/regBlock.sv
design/busReg.sv
design/datapath.sv
design/controlFsm.sv
design/waitTimer.sv
design/cpuTop.sv
dv/cpuChecker.sv
dv/cpuTb.sv

//--- build.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module cpuTb -f files.f -o cpuSim; then
	echo "verilator build failed"
	exit 1
fi

if ! out=$(./obj_dir/cpuSim); then
	echo "$out"
	echo "simulation did not run to completion"
	exit 1
fi
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1
